// File: build.f
hdl/perf_pkg.sv
hdl/perf_event_if.sv
hdl/perf_event_sync.sv
hdl/perf_counter_bank.sv
hdl/perf_mmio_decode.sv
hdl/perf_counters_top.sv
tests/perf_counters_chk.sv
tests/tb_perf_counters.sv

// File: hdl/perf_counter_bank.sv
`timescale 1ns/1ps

module perf_counter_bank #(
    parameter int CNT_W = 16
) (
    input  logic       clk,
    input  logic       i_rst_n,
    perf_event_if.bank ev
);
    import perf_pkg::*;

    ////////////////////
    // saturating counters
    ////////////////////

    for (genvar k = 0; k < NUM_EVENTS; k++) begin : g_cnt
        logic [CNT_W-1:0] count_q;
        logic             saturated;
        logic             inc_en;

        // a counter at all ones holds its value instead of wrapping to zero.
        assign saturated = &count_q;
        assign inc_en    = ev.evt[k] && !saturated;

        // a clear wins over an increment that lands in the same cycle.
        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                count_q <= '0;
            end else if (ev.clr[k]) begin
                count_q <= '0;
            end else if (inc_en) begin
                count_q <= count_q + 1'b1;
            end
        end

        assign ev.cnt[k] = count_q;
    end

endmodule : perf_counter_bank

// File: hdl/perf_counters_top.sv
`timescale 1ns/1ps

module perf_counters_top #(
    parameter int CNT_W = 16
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic [perf_pkg::NUM_EVENTS-1:0] i_events,
    input  logic                            i_mem_access,
    input  logic                            i_mem_we,
    input  logic [perf_pkg::ADDR_W-1:0]     i_mem_addr,
    output logic                            o_mem_cancel,
    output logic [perf_pkg::DATA_W-1:0]     o_mem_rdata
);

    // one bundle carries the events in, the clears across and the counts out.
    perf_event_if #(
        .CNT_W (CNT_W)
    ) u_ev_if ();

    ////////////////////
    // input side
    ////////////////////

    perf_event_sync u_event_sync (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_events (i_events),
        .ev       (u_ev_if.sync)
    );

    ////////////////////
    // counters
    ////////////////////

    perf_counter_bank #(
        .CNT_W (CNT_W)
    ) u_counter_bank (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .ev      (u_ev_if.bank)
    );

    ////////////////////
    // memory-mapped access
    ////////////////////

    // the decode is combinational, so cancel and read data answer the access
    // in the cycle it is presented.
    perf_mmio_decode #(
        .CNT_W (CNT_W)
    ) u_mmio_decode (
        .i_mem_access (i_mem_access),
        .i_mem_we     (i_mem_we),
        .i_mem_addr   (i_mem_addr),
        .o_mem_cancel (o_mem_cancel),
        .o_mem_rdata  (o_mem_rdata),
        .ev           (u_ev_if.decode)
    );

endmodule : perf_counters_top

// File: hdl/perf_event_if.sv
`timescale 1ns/1ps

interface perf_event_if #(
    parameter int CNT_W = 16
) ();
    import perf_pkg::*;

    // registered event strobes, one bit per counter.
    logic [NUM_EVENTS-1:0] evt;

    // clear strobes from a write to a counter address.
    logic [NUM_EVENTS-1:0] clr;

    // current value of every counter.
    logic [NUM_EVENTS-1:0][CNT_W-1:0] cnt;

    modport sync (
        output evt
    );

    modport bank (
        input  evt,
        input  clr,
        output cnt
    );

    modport decode (
        output clr,
        input  cnt
    );

endinterface : perf_event_if

// File: hdl/perf_event_sync.sv
`timescale 1ns/1ps

module perf_event_sync (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic [perf_pkg::NUM_EVENTS-1:0] i_events,
    perf_event_if.sync                      ev
);
    import perf_pkg::*;

    // the strobes come from the caches, the pipeline and the branch predictor.
    // One register stage here keeps those paths out of the counter adders.
    logic [NUM_EVENTS-1:0] evt_q;

    ////////////////////
    // event register
    ////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            evt_q <= '0;
        end else begin
            evt_q <= i_events;
        end
    end

    // each bit is a single-cycle strobe, so nothing is held or merged.
    assign ev.evt = evt_q;

endmodule : perf_event_sync

// File: hdl/perf_mmio_decode.sv
`timescale 1ns/1ps

module perf_mmio_decode #(
    parameter int CNT_W = 16
) (
    input  logic                        i_mem_access,
    input  logic                        i_mem_we,
    input  logic [perf_pkg::ADDR_W-1:0] i_mem_addr,
    output logic                        o_mem_cancel,
    output logic [perf_pkg::DATA_W-1:0] o_mem_rdata,
    perf_event_if.decode                ev
);
    import perf_pkg::*;

    logic                  in_window;
    logic                  on_counter;
    logic                  rd_hit;
    logic                  wr_hit;
    logic [EV_IDX_W:0]     offset;
    perf_event_e           sel_ev;
    logic [NUM_EVENTS-1:0] clr_d;
    logic [DATA_W-1:0]     rdata_d;

    ////////////////////
    // address decode
    ////////////////////

    // everything from the base upward belongs to the counters, so the core
    // must not send those accesses on to the data cache.
    assign in_window = (i_mem_addr >= PERF_BASE);

    // only even addresses up to the last counter name a counter.
    assign on_counter = in_window && (i_mem_addr <= PERF_LAST) && !i_mem_addr[0];

    // the window spans fewer than 32 bytes, so the low bits of the
    // difference are enough to find the word.
    assign offset = (EV_IDX_W + 1)'(i_mem_addr - PERF_BASE);
    assign sel_ev = perf_event_e'(offset[EV_IDX_W:1]);

    assign rd_hit = i_mem_access && !i_mem_we && on_counter;
    assign wr_hit = i_mem_access && i_mem_we && on_counter;

    assign o_mem_cancel = i_mem_access && in_window;

    ////////////////////
    // clear strobes
    ////////////////////

    // the write data is ignored, the write itself is the clear.
    always_comb begin
        clr_d = '0;
        for (int k = 0; k < NUM_EVENTS; k++) begin
            if (wr_hit && (sel_ev == perf_event_e'(k))) begin
                clr_d[k] = 1'b1;
            end
        end
    end

    assign ev.clr = clr_d;

    ////////////////////
    // read data
    ////////////////////

    // the counter is zero-extended or cut to the word width of the data bus.
    always_comb begin
        rdata_d = '0;
        for (int k = 0; k < NUM_EVENTS; k++) begin
            if (rd_hit && (sel_ev == perf_event_e'(k))) begin
                rdata_d = DATA_W'(ev.cnt[k]);
            end
        end
    end

    // any access that is not a counter read returns zero.
    assign o_mem_rdata = rdata_d;

endmodule : perf_mmio_decode

// File: hdl/perf_pkg.sv
package perf_pkg;

    ////////////////////
    // widths of the data memory port.
    ////////////////////

    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    ////////////////////
    // event kinds and counter count.
    ////////////////////

    localparam int NUM_EVENTS = 13;

    // wide enough to index every counter.
    localparam int EV_IDX_W = $clog2(NUM_EVENTS);

    // the enumerator value is also the counter index, so the order follows the address map.
    typedef enum logic [EV_IDX_W-1:0] {
        EV_BP_CORRECT = 4'd0,
        EV_BP_WRONG   = 4'd1,
        EV_IC_HIT     = 4'd2,
        EV_IC_MISS    = 4'd3,
        EV_DC_HIT     = 4'd4,
        EV_DC_MISS    = 4'd5,
        EV_L2_HIT     = 4'd6,
        EV_L2_MISS    = 4'd7,
        EV_IF_STALL   = 4'd8,
        EV_ID_STALL   = 4'd9,
        EV_EX_STALL   = 4'd10,
        EV_MEM_STALL  = 4'd11,
        EV_WB_STALL   = 4'd12
    } perf_event_e;

    ////////////////////
    // address window.
    ////////////////////

    // counter k sits at PERF_BASE + 2k, one counter per 16-bit word.
    localparam logic [ADDR_W-1:0] PERF_BASE = 16'hFFE6;

    // address of the last counter in the window.
    localparam logic [ADDR_W-1:0] PERF_LAST = PERF_BASE + ADDR_W'(2 * (NUM_EVENTS - 1));

endpackage : perf_pkg

// File: run_sim.sh
#!/bin/sh
# Compile and run the performance counter testbench with Verilator.
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_perf_counters \
    -Mdir "$OBJ_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
exit 0

// File: tests/perf_counters_chk.sv
`timescale 1ns/1ps

module perf_counters_chk #(
    parameter int CNT_W = 16
) (
    input logic                                       clk,
    input logic                                       i_rst_n,
    input logic                                       i_mem_access,
    input logic                                       i_mem_cancel,
    input logic [perf_pkg::DATA_W-1:0]                i_mem_rdata,
    input logic [perf_pkg::NUM_EVENTS-1:0]            i_clr,
    input logic [perf_pkg::NUM_EVENTS-1:0][CNT_W-1:0] i_cnt
);
    import perf_pkg::*;

    a_cancel_needs_access: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_cancel |-> i_mem_access)
        else $error("cancel is high without a memory access");

    a_rdata_idle_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_mem_access |-> (i_mem_rdata == '0))
        else $error("read data is not zero without a memory access");

    // a counter only moves down through a clear in the cycle before.
    for (genvar k = 0; k < NUM_EVENTS; k++) begin : g_mono
        a_no_decrease: assert property (@(posedge clk) disable iff (!i_rst_n)
            !$past(i_clr[k]) |-> (i_cnt[k] >= $past(i_cnt[k])))
            else $error("counter %0d decreased without a clear", k);
    end

endmodule : perf_counters_chk

bind perf_counters_top perf_counters_chk #(
    .CNT_W (CNT_W)
) u_chk (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_mem_access (i_mem_access),
    .i_mem_cancel (o_mem_cancel),
    .i_mem_rdata  (o_mem_rdata),
    .i_clr        (u_ev_if.clr),
    .i_cnt        (u_ev_if.cnt)
);

// File: tests/tb_perf_counters.sv
`timescale 1ns/1ps

module tb_perf_counters;
    import perf_pkg::*;

    localparam int CNT_W          = 16;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int TRAFFIC_CYCLES = 2000;
    localparam logic [CNT_W-1:0]  CNT_MAX   = '1;
    localparam logic [ADDR_W-1:0] LAST_ADDR = PERF_BASE + ADDR_W'(2 * (NUM_EVENTS - 1));

    logic                  clk = 1'b0;
    logic                  i_rst_n;
    logic [NUM_EVENTS-1:0] i_events;
    logic                  i_mem_access;
    logic                  i_mem_we;
    logic [ADDR_W-1:0]     i_mem_addr;
    logic                  o_mem_cancel;
    logic [DATA_W-1:0]     o_mem_rdata;

    // copies of what is on the DUT inputs during the current cycle.
    logic [NUM_EVENTS-1:0] drv_events;
    logic                  drv_access;
    logic                  drv_we;
    logic [ADDR_W-1:0]     drv_addr;

    logic [CNT_W-1:0]      model_cnt [NUM_EVENTS];
    logic [NUM_EVENTS-1:0] model_evt_q;

    // fixed corner addresses around the window edges.
    logic [ADDR_W-1:0] addr_list [9] = '{16'h0000, 16'h1234, 16'hFFE4, 16'hFFE5, 16'hFFE6,
                                         16'hFFE7, 16'hFFF1, 16'hFFFE, 16'hFFFF};

    string       test_name;
    int          test_checks = 0;
    int          test_errors = 0;
    int          total_checks = 0;
    int          total_errors = 0;
    int          cycle_cnt = 0;

    perf_counters_top #(
        .CNT_W (CNT_W)
    ) u_perf_counters_top (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_events     (i_events),
        .i_mem_access (i_mem_access),
        .i_mem_we     (i_mem_we),
        .i_mem_addr   (i_mem_addr),
        .o_mem_cancel (o_mem_cancel),
        .o_mem_rdata  (o_mem_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic bit is_counter_addr(input logic [ADDR_W-1:0] addr);
        return (addr >= PERF_BASE) && (addr <= LAST_ADDR) && !addr[0];
    endfunction

    function automatic int addr_index(input logic [ADDR_W-1:0] addr);
        return int'(addr - PERF_BASE) / 2;
    endfunction

    function automatic logic [ADDR_W-1:0] counter_addr(input int k);
        return PERF_BASE + ADDR_W'(2 * k);
    endfunction

    // each clock edge applies the clears first and then the events registered one edge ago.
    task automatic advance_model();
        for (int k = 0; k < NUM_EVENTS; k++) begin
            if (drv_access && drv_we && is_counter_addr(drv_addr) && addr_index(drv_addr) == k) begin
                model_cnt[k] = '0;
            end else if (model_evt_q[k] && model_cnt[k] != CNT_MAX) begin
                model_cnt[k] = model_cnt[k] + CNT_W'(1);
            end
        end
        model_evt_q = drv_events;
    endtask

    function automatic logic [DATA_W-1:0] expected_rdata();
        if (drv_access && !drv_we && is_counter_addr(drv_addr)) begin
            return DATA_W'(model_cnt[addr_index(drv_addr)]);
        end
        return '0;
    endfunction

    ////////////////////
    // stimulus and checks
    ////////////////////

    task automatic check_value(input string what, input logic [DATA_W-1:0] exp_val,
                               input logic [DATA_W-1:0] act_val);
        test_checks++;
        if (act_val !== exp_val) begin
            test_errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp_val,
                     act_val);
        end
    endtask

    // drives one cycle and checks cancel and read data once they have settled.
    task automatic drive_cycle(input logic [NUM_EVENTS-1:0] ev, input logic acc,
                               input logic we, input logic [ADDR_W-1:0] addr);
        @(posedge clk);
        advance_model();
        i_events     <= ev;
        i_mem_access <= acc;
        i_mem_we     <= we;
        i_mem_addr   <= addr;
        drv_events = ev;
        drv_access = acc;
        drv_we     = we;
        drv_addr   = addr;
        @(negedge clk);
        check_value("cancel", DATA_W'(acc && (addr >= PERF_BASE)), DATA_W'(o_mem_cancel));
        check_value("rdata", expected_rdata(), o_mem_rdata);
    endtask

    function automatic logic [NUM_EVENTS-1:0] random_events();
        return NUM_EVENTS'($urandom);
    endfunction

    function automatic logic [ADDR_W-1:0] random_addr();
        if ($urandom % 2 == 0) begin
            return PERF_BASE + ADDR_W'($urandom % 26);
        end
        return ADDR_W'($urandom);
    endfunction

    task automatic read_all_counters();
        for (int k = 0; k < NUM_EVENTS; k++) begin
            drive_cycle(random_events(), 1'b1, 1'b0, counter_addr(k));
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %s finished: %0d checks, %0d errors", test_name, test_checks,
                 test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    initial begin
        logic [NUM_EVENTS-1:0] ev;
        logic [ADDR_W-1:0]     addr;
        int                    k;
        int                    n_hold;
        int                    exp_cnt;

        i_rst_n      = 1'b0;
        i_events     = '0;
        i_mem_access = 1'b0;
        i_mem_we     = 1'b0;
        i_mem_addr   = '0;
        drv_events   = '0;
        drv_access   = 1'b0;
        drv_we       = 1'b0;
        drv_addr     = '0;
        model_evt_q  = '0;
        for (int j = 0; j < NUM_EVENTS; j++) begin
            model_cnt[j] = '0;
        end
        void'($urandom(32'hfb4e));
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;

        start_test("reset_reads");
        for (int j = 0; j < NUM_EVENTS; j++) begin
            drive_cycle('0, 1'b1, 1'b0, counter_addr(j));
            check_value($sformatf("counter %0d", j), '0, o_mem_rdata);
        end
        finish_test();

        start_test("random_traffic");
        repeat (TRAFFIC_CYCLES) begin
            drive_cycle(random_events(), ($urandom % 4) == 0, ($urandom % 8) == 0, random_addr());
        end
        read_all_counters();
        finish_test();

        // the event lands in the sync register as the write arrives, so
        // the clear and the increment meet at the same edge.
        start_test("clear_counters");
        repeat (20) begin
            k = int'($urandom % NUM_EVENTS);
            ev = random_events();
            ev[k] = 1'b1;
            drive_cycle(ev, 1'b0, 1'b0, '0);
            ev = random_events();
            ev[k] = 1'b0;
            drive_cycle(ev, 1'b1, 1'b1, counter_addr(k));
            drive_cycle(random_events(), 1'b1, 1'b0, counter_addr(k));
            check_value($sformatf("cleared counter %0d", k), '0, o_mem_rdata);
        end
        read_all_counters();
        finish_test();

        start_test("cancel_window");
        foreach (addr_list[j]) begin
            drive_cycle(random_events(), 1'b1, 1'b0, addr_list[j]);
            check_value($sformatf("cancel at %h", addr_list[j]),
                        DATA_W'(addr_list[j] >= 16'hFFE6), DATA_W'(o_mem_cancel));
            if (addr_list[j] < 16'hFFE6) begin
                check_value($sformatf("rdata at %h", addr_list[j]), '0, o_mem_rdata);
            end
            drive_cycle(random_events(), 1'b1, 1'b1, addr_list[j]);
            drive_cycle(random_events(), 1'b0, 1'b0, addr_list[j]);
            check_value("cancel without access", '0, DATA_W'(o_mem_cancel));
        end
        repeat (30) begin
            addr = ADDR_W'($urandom);
            drive_cycle(random_events(), 1'b1, $urandom % 2 == 0, addr);
        end
        read_all_counters();
        finish_test();

        // a narrow build holds the event past the top of the counter.
        start_test("saturation");
        k = int'(EV_L2_MISS);
        n_hold = (CNT_W <= 8) ? (1 << CNT_W) + 44 : 300;
        exp_cnt = (n_hold < int'(CNT_MAX)) ? n_hold : int'(CNT_MAX);
        drive_cycle('0, 1'b1, 1'b1, counter_addr(k));
        drive_cycle('0, 1'b0, 1'b0, '0);
        ev = '0;
        ev[k] = 1'b1;
        repeat (n_hold) drive_cycle(ev, 1'b0, 1'b0, '0);
        repeat (2) drive_cycle('0, 1'b0, 1'b0, '0);
        drive_cycle('0, 1'b1, 1'b0, counter_addr(k));
        check_value("held event count", DATA_W'(exp_cnt), o_mem_rdata);
        finish_test();

        $display("all tests: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_perf_counters
